// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_fp_addsub
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := all tests passed

# Sources come from the file list, headers are added by hand
SOURCES   := $(shell grep -v '^+' $(FILELIST)) fp_defines.svh tb_fp_ref.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation reported failure"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: fp_addsub_core.sv
`include "fp_defines.svh"

module fp_addsub_core (
  input  fp_pkg::fp32_t   rs1_i,
  input  fp_pkg::fp32_t   rs2_i,
  input  logic            sub_i,
  input  fp_pkg::frm_t    frm_i,
  output fp_pkg::fp32_t   result_o,
  output fp_pkg::fflags_t fflags_o
);
  import fp_pkg::*;

  amant_t     a_m;        // Aligned mantissas from the aligner
  amant_t     b_m;
  fp_exp_t    exp_c;      // Shared exponent
  logic       sign_a;
  logic       sign_b;     // Already flipped for subtraction
  logic       a_ge_b;
  amant_t     big_m;
  amant_t     little_m;
  logic       eff_sub;
  logic       res_sign;
  logic [27:0] raw;       // Carry, hidden, fraction, GRS
  logic [4:0] lead_pos;
  logic       lead_zero;
  logic [4:0] lz;         // Left shift to bring the leading one up
  fp_exp_t    lim;        // Largest shift that keeps the exponent at 1
  logic [4:0] shl;
  amant_t     norm;
  logic [8:0] exp_n;
  logic [8:0] exp_pre;    // Encoded exponent, 0 for subnormal
  fp_mant_t   frac;
  logic       last;
  logic       guard;
  logic       sticky;
  logic       inexact;
  logic [31:0] trunc;     // {exp_pre, frac}
  logic [31:0] inc;
  logic       round_up;
  logic [31:0] rnd;
  logic [8:0] rnd_exp;
  logic       of;
  logic       tiny;
  logic       ovf_inf;
  logic       zero_sign;

  fp_exp_align u_align (
    .a_i         (rs1_i),
    .b_i         ({rs2_i[31] ^ sub_i, rs2_i[30:0]}), // Effective sign of rs2
    .a_aligned_o (a_m),
    .b_aligned_o (b_m),
    .exp_o       (exp_c),
    .sign_a_o    (sign_a),
    .sign_b_o    (sign_b)
  );

  // Magnitude operation, always big minus little so no negative result
  assign a_ge_b   = a_m >= b_m;
  assign big_m    = a_ge_b ? a_m : b_m;
  assign little_m = a_ge_b ? b_m : a_m;
  assign eff_sub  = sign_a ^ sign_b;
  assign res_sign = a_ge_b ? sign_a : sign_b;
  assign raw      = eff_sub ? {1'b0, big_m} - {1'b0, little_m}
                            : {1'b0, big_m} + {1'b0, little_m};

  fp_lead_one u_lead (
    .mant_i (raw),
    .pos_o  (lead_pos),
    .zero_o (lead_zero)
  );

  // Renormalize
  assign lz  = 5'd26 - lead_pos;
  assign lim = exp_c - 8'd1;
  assign shl = ({3'b000, lz} > lim) ? lim[4:0] : lz; // Stop at exponent 1, result goes subnormal

  assign norm  = raw[27] ? {raw[27:2], |raw[1:0]} : raw[26:0] << shl;
  assign exp_n = raw[27] ? {1'b0, exp_c} + 9'd1 : {1'b0, exp_c} - {4'b0000, shl};
  // Hidden bit decides normal or subnormal, also catches subnormal carry into normal range
  assign exp_pre = norm[26] ? exp_n : 9'd0;

  assign frac    = norm[25:3];
  assign last    = norm[3];
  assign guard   = norm[2];
  assign sticky  = |norm[1:0];
  assign inexact = guard | sticky;

  // Incrementing exponent and fraction together carries straight into the exponent
  assign trunc = {exp_pre, frac};
  assign inc   = trunc + 32'd1;

  always_comb begin
    case (frm_i)
      `FRM_RNE: round_up = guard & (sticky | last);
      `FRM_RTZ: round_up = 1'b0;
      `FRM_RDN: round_up = res_sign & inexact;
      `FRM_RUP: round_up = ~res_sign & inexact;
      `FRM_RMM: round_up = guard;
      default:  round_up = 1'b0; // Reserved codes are caught in the top level
    endcase
  end

  assign rnd     = round_up ? inc : trunc;
  assign rnd_exp = rnd[31:23];

  assign of   = rnd_exp >= {1'b0, `FP_EXP_MAX};
  assign tiny = rnd_exp == 9'd0; // Judged on the rounded result
  // Overflow goes to inf unless the mode points back toward zero
  assign ovf_inf = (frm_i == `FRM_RNE) | (frm_i == `FRM_RMM) |
                   ((frm_i == `FRM_RUP) & ~res_sign) | ((frm_i == `FRM_RDN) & res_sign);

  // Same-signed zeros keep their sign, true cancellation follows the mode
  assign zero_sign = (sign_a == sign_b) ? sign_a : (frm_i == `FRM_RDN);

  always_comb begin
    fflags_o = '0;
    if (lead_zero) begin
      result_o = {zero_sign, 31'd0}; // Exact zero, no flags
    end else if (of) begin
      result_o = ovf_inf ? {res_sign, `FP_EXP_MAX, 23'd0}
                         : {res_sign, `FP_EXP_MAX - 8'd1, {23{1'b1}}};
      fflags_o[`FLAG_OF] = 1'b1;
      fflags_o[`FLAG_NX] = 1'b1;
    end else begin
      result_o = {res_sign, rnd[30:0]};
      fflags_o[`FLAG_UF] = tiny & inexact;
      fflags_o[`FLAG_NX] = inexact;
    end
  end

  always_comb begin
    // Encoder output points at the top set bit
    assert (lead_zero || (raw >> lead_pos) == 28'd1)
      else $error("lead-one position %0d is not the top set bit", lead_pos);
    // Overflow only from the top exponents
    assert (!of || exp_c >= 8'd253)
      else $error("OF raised with shared exponent %0d", exp_c);
  end

endmodule

// File: fp_addsub_unit.sv
`include "fp_defines.svh"

module fp_addsub_unit (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            valid_i,
  input  logic            sub_i,
  input  fp_pkg::fp32_t   rs1_i,
  input  fp_pkg::fp32_t   rs2_i,
  input  fp_pkg::frm_t    frm_i,
  output logic            valid_o,
  output fp_pkg::fp32_t   result_o,
  output fp_pkg::fflags_t fflags_o
);
  import fp_pkg::*;

  fp32_t   core_result;
  fflags_t core_flags;
  logic    special;
  fp32_t   spec_result;
  fflags_t spec_flags;
  logic    frm_bad;     // Codes 5 to 7 are reserved
  fp32_t   sel_result;
  fflags_t sel_flags;

  fp_addsub_core u_core (
    .rs1_i    (rs1_i),
    .rs2_i    (rs2_i),
    .sub_i    (sub_i),
    .frm_i    (frm_i),
    .result_o (core_result),
    .fflags_o (core_flags)
  );

  fp_special_case u_special (
    .rs1_i         (rs1_i),
    .rs2_i         (rs2_i),
    .sub_i         (sub_i),
    .special_o     (special),
    .spec_result_o (spec_result),
    .spec_flags_o  (spec_flags)
  );

  assign frm_bad = frm_i > `FRM_RMM;

  // Reserved mode first, then NaN/inf, then the arithmetic core
  always_comb begin
    sel_flags = '0;
    if (frm_bad) begin
      sel_result = `FP_QNAN;
      sel_flags[`FLAG_NV] = 1'b1;
    end else if (special) begin
      sel_result = spec_result;
      sel_flags  = spec_flags;
    end else begin
      sel_result = core_result;
      sel_flags  = core_flags;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o  <= 1'b0;
      result_o <= '0;
      fflags_o <= '0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin // Held until the next strobe
        result_o <= sel_result;
        fflags_o <= sel_flags;
      end
    end
  end

  a_valid_lat: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_i |=> valid_o && result_o == $past(sel_result))
    else $error("valid_o or result missing one cycle after valid_i");

  // NaN and inf operands never reach the core result
  a_special_wins: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_i && !frm_bad && (rs1_i[30:23] == `FP_EXP_MAX || rs2_i[30:23] == `FP_EXP_MAX)
      |=> result_o[30:23] == `FP_EXP_MAX && !fflags_o[`FLAG_OF])
    else $error("NaN or inf operand did not give a NaN or inf result");

endmodule

// File: fp_defines.svh
`ifndef FP_DEFINES_SVH
`define FP_DEFINES_SVH

// Rounding mode codes as carried in frm
`define FRM_RNE 3'b000 // Nearest, ties to even
`define FRM_RTZ 3'b001 // Toward zero
`define FRM_RDN 3'b010 // Toward -inf
`define FRM_RUP 3'b011 // Toward +inf
`define FRM_RMM 3'b100 // Nearest, ties to max magnitude

// Bit positions inside fflags
`define FLAG_NV 4
`define FLAG_DZ 3
`define FLAG_OF 2
`define FLAG_UF 1
`define FLAG_NX 0

`define FP_QNAN    32'h7fc0_0000 // Canonical quiet NaN
`define FP_EXP_MAX 8'hff         // All-ones exponent, inf and NaN

// Field widths of the single precision format
`define FP_WIDTH   32
`define FP_EXP_W   8
`define FP_MANT_W  23
`define FP_FRM_W   3
`define FP_FLAGS_W 5
`define FP_AMANT_W 27 // Hidden bit, fraction, guard, round, sticky

`endif

// File: fp_exp_align.sv
module fp_exp_align (
  input  fp_pkg::fp32_t   a_i,
  input  fp_pkg::fp32_t   b_i,
  output fp_pkg::amant_t  a_aligned_o,
  output fp_pkg::amant_t  b_aligned_o,
  output fp_pkg::fp_exp_t exp_o,
  output logic            sign_a_o,
  output logic            sign_b_o
);
  import fp_pkg::*;

  fp_exp_t    exp_a;     // Effective exponents
  fp_exp_t    exp_b;
  amant_t     mant_a;    // Hidden bit plus fraction, GRS still empty
  amant_t     mant_b;
  logic       a_big;     // rs1 holds the larger exponent
  fp_exp_t    diff;
  logic [4:0] shamt;     // Saturated shift distance
  amant_t     small_m;
  amant_t     shifted;
  amant_t     lost_mask; // Ones where bits fall off the right end
  logic       sticky;
  amant_t     small_al;

  // Subnormals behave as exponent 1 without the hidden bit
  assign exp_a  = (a_i[30:23] == 8'd0) ? 8'd1 : a_i[30:23];
  assign exp_b  = (b_i[30:23] == 8'd0) ? 8'd1 : b_i[30:23];
  assign mant_a = {|a_i[30:23], a_i[22:0], 3'b000};
  assign mant_b = {|b_i[30:23], b_i[22:0], 3'b000};

  assign a_big = exp_a >= exp_b;
  assign diff  = a_big ? exp_a - exp_b : exp_b - exp_a;
  assign shamt = (diff > 8'd27) ? 5'd27 : diff[4:0]; // Past 27 everything is sticky anyway

  assign small_m   = a_big ? mant_b : mant_a;
  assign shifted   = small_m >> shamt;
  assign lost_mask = ~({27{1'b1}} << shamt);
  assign sticky    = |(small_m & lost_mask);

  // Shifted-out bits collapse into the LSB
  assign small_al = {shifted[26:1], shifted[0] | sticky};

  assign a_aligned_o = a_big ? mant_a : small_al;
  assign b_aligned_o = a_big ? small_al : mant_b;
  assign exp_o       = a_big ? exp_a : exp_b; // Common exponent after alignment
  assign sign_a_o    = a_i[31];
  assign sign_b_o    = b_i[31];

endmodule

// File: fp_lead_one.sv
module fp_lead_one (
  input  logic [27:0] mant_i,
  output logic [4:0]  pos_o,
  output logic        zero_o
);

  // Priority encoder, the last hit in the upward scan is the highest one
  always_comb begin
    pos_o = 5'd0;
    for (int i = 0; i < 28; i++) begin
      if (mant_i[i]) begin
        pos_o = 5'(i);
      end
    end
  end

  // No bit set at all, pos_o reads 0 then
  assign zero_o = ~|mant_i;

endmodule

// File: fp_pkg.sv
`include "fp_defines.svh"

package fp_pkg;

  // Whole single precision word, sign at the top
  typedef logic [`FP_WIDTH-1:0] fp32_t;

  // Biased exponent field
  typedef logic [`FP_EXP_W-1:0] fp_exp_t;

  // Stored fraction without the hidden bit
  typedef logic [`FP_MANT_W-1:0] fp_mant_t;

  // Rounding mode as seen on the port
  typedef logic [`FP_FRM_W-1:0] frm_t;

  // Flags NV, DZ, OF, UF, NX from MSB down
  typedef logic [`FP_FLAGS_W-1:0] fflags_t;

  // Aligned mantissa, hidden bit at the top and GRS at the bottom
  typedef logic [`FP_AMANT_W-1:0] amant_t;

endpackage

// File: fp_special_case.sv
`include "fp_defines.svh"

module fp_special_case (
  input  fp_pkg::fp32_t   rs1_i,
  input  fp_pkg::fp32_t   rs2_i,
  input  logic            sub_i,
  output logic            special_o,
  output fp_pkg::fp32_t   spec_result_o,
  output fp_pkg::fflags_t spec_flags_o
);
  import fp_pkg::*;

  logic a_exp_max;
  logic b_exp_max;
  logic a_nan;
  logic b_nan;
  logic a_snan;   // Quiet bit clear
  logic b_snan;
  logic a_inf;
  logic b_inf;
  logic sign_a;
  logic sign_b;   // Effective sign after subtraction

  assign a_exp_max = rs1_i[30:23] == `FP_EXP_MAX;
  assign b_exp_max = rs2_i[30:23] == `FP_EXP_MAX;
  assign a_nan     = a_exp_max & (|rs1_i[22:0]);
  assign b_nan     = b_exp_max & (|rs2_i[22:0]);
  assign a_snan    = a_nan & ~rs1_i[22];
  assign b_snan    = b_nan & ~rs2_i[22];
  assign a_inf     = a_exp_max & ~(|rs1_i[22:0]);
  assign b_inf     = b_exp_max & ~(|rs2_i[22:0]);
  assign sign_a    = rs1_i[31];
  assign sign_b    = rs2_i[31] ^ sub_i;

  assign special_o = a_nan | b_nan | a_inf | b_inf;

  always_comb begin
    spec_result_o = `FP_QNAN; // Also the idle value when nothing is special
    spec_flags_o  = '0;
    if (a_nan | b_nan) begin
      spec_flags_o[`FLAG_NV] = a_snan | b_snan; // Quiet NaNs pass silently
    end else if (a_inf & b_inf & (sign_a != sign_b)) begin
      spec_flags_o[`FLAG_NV] = 1'b1;              // inf - inf
    end else if (a_inf) begin
      spec_result_o = {sign_a, `FP_EXP_MAX, 23'd0};
    end else if (b_inf) begin
      spec_result_o = {sign_b, `FP_EXP_MAX, 23'd0};
    end
  end

endmodule

// File: tb_fp_ref.svh
`ifndef TB_FP_REF_SVH
`define TB_FP_REF_SVH

// 32-bit xorshift step, shifts 13, 17, 5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

// IEEE rounding decision for one magnitude
function automatic logic round_inc(input frm_t frm, input logic sign, input logic lsb,
                                   input logic grd, input logic stk);
  case (frm)
    `FRM_RNE: return grd && (stk || lsb); // Tie goes to even
    `FRM_RTZ: return 1'b0;
    `FRM_RDN: return sign && (grd || stk);
    `FRM_RUP: return !sign && (grd || stk);
    `FRM_RMM: return grd;                 // Tie goes away from zero
    default:  return 1'b0;
  endcase
endfunction

// Expected result and flags of rs1 +/- rs2
function automatic void ref_fadd(input fp32_t a, input fp32_t b, input logic sub,
                                 input frm_t frm, output fp32_t res, output fflags_t flg);
  logic        sa;
  logic        sb;
  logic        bs;
  logic        ls;
  logic        rs;
  logic        a_nan;
  logic        b_nan;
  logic        a_inf;
  logic        b_inf;
  logic        grd;
  logic        stk;
  int          ea;
  int          eb;
  int          emax;
  int          d;
  int          p;
  int          s;
  int          be;
  logic [63:0] big;
  logic [63:0] lit;
  logic [63:0] mag;
  logic [63:0] sig;
  res   = '0;
  flg   = '0;
  sa    = a[31];
  sb    = b[31] ^ sub;
  a_nan = (a[30:23] == 8'hff) && (a[22:0] != 23'd0);
  b_nan = (b[30:23] == 8'hff) && (b[22:0] != 23'd0);
  a_inf = (a[30:23] == 8'hff) && (a[22:0] == 23'd0);
  b_inf = (b[30:23] == 8'hff) && (b[22:0] == 23'd0);
  if (frm > `FRM_RMM || a_nan || b_nan || (a_inf && b_inf && sa != sb)) begin
    res = `FP_QNAN;
    // Reserved mode, signaling NaN or inf - inf
    flg[`FLAG_NV] = (frm > `FRM_RMM) || (a_nan && !a[22]) || (b_nan && !b[22]) ||
                    (!a_nan && !b_nan);
    return;
  end
  if (a_inf || b_inf) begin
    res = a_inf ? {sa, 8'hff, 23'd0} : {sb, 8'hff, 23'd0};
    return;
  end
  // Subnormals sit at exponent 1, 30 spare bits below the fraction
  ea = (a[30:23] == 8'd0) ? 1 : int'(a[30:23]);
  eb = (b[30:23] == 8'd0) ? 1 : int'(b[30:23]);
  big = {40'd0, |a[30:23], a[22:0]} << 30;
  lit = {40'd0, |b[30:23], b[22:0]} << 30;
  bs  = sa;
  ls  = sb;
  if (eb > ea) begin
    big = {40'd0, |b[30:23], b[22:0]} << 30;
    lit = {40'd0, |a[30:23], a[22:0]} << 30;
    bs  = sb;
    ls  = sa;
  end
  emax = (ea > eb) ? ea : eb;
  d    = (ea > eb) ? ea - eb : eb - ea;
  mag  = lit >> d;
  if ((mag << d) != lit) mag = mag | 64'd1; // Lost bits kept as sticky
  lit = mag;
  rs  = bs;
  if (bs == ls) mag = big + lit;
  else if (big >= lit) mag = big - lit;
  else begin
    mag = lit - big;
    rs  = ls;
  end
  if (mag == 64'd0) begin
    res = {(bs == ls) ? bs : (frm == `FRM_RDN), 31'd0}; // Exact zero
    return;
  end
  p = 63;
  while (!mag[p]) p--;
  s = p - 23;
  if (s < 31 - emax) s = 31 - emax; // Exponent floor, result goes subnormal
  sig = mag >> s;
  grd = mag[s-1];
  stk = (mag & ((64'd1 << (s - 1)) - 64'd1)) != 64'd0;
  be  = s + emax - 30;
  if (round_inc(frm, rs, sig[0], grd, stk)) sig = sig + 64'd1;
  if (sig[24]) begin // Rounding carried out of the significand
    sig = sig >> 1;
    be  = be + 1;
  end
  if (!sig[23]) be = 0;
  if (be >= 255) begin
    if (frm == `FRM_RNE || frm == `FRM_RMM || (frm == `FRM_RUP && !rs) ||
        (frm == `FRM_RDN && rs))
      res = {rs, 8'hff, 23'd0};
    else
      res = {rs, 8'hfe, 23'h7f_ffff}; // Largest finite
    flg[`FLAG_OF] = 1'b1;
    flg[`FLAG_NX] = 1'b1;
    return;
  end
  res = {rs, be[7:0], sig[22:0]};
  flg[`FLAG_NX] = grd || stk;
  flg[`FLAG_UF] = (be == 0) && (grd || stk); // Tiny after rounding
endfunction

`endif

// File: tb_fp_addsub.sv
`include "fp_defines.svh"

module tb_fp_addsub;
  import fp_pkg::*;

  `include "tb_fp_ref.svh"

  localparam int CLK_PERIOD = 8;
  localparam int N_RAND     = 100; // Random pairs, reused in every mode
  localparam int N_CANCEL   = 8;
  localparam int N_SPEC     = 6;
  localparam int N_EDGE     = 10;
  localparam int N_RSV      = 8;   // Vectors per reserved frm code
  localparam int N_VEC      = N_RAND * 10 + 5 * (N_CANCEL * 2 + 8) + N_SPEC * N_SPEC * 2 +
                              N_EDGE * N_EDGE * 10 + 3 * N_RSV;

  // Inf, -inf, qNaN, sNaN, negative qNaN with payload, 1.0
  localparam fp32_t SPEC_VALS [N_SPEC] = '{32'h7f80_0000, 32'hff80_0000, 32'h7fc0_0000,
                                            32'h7f80_0001, 32'hffc1_2345, 32'h3f80_0000};
  // Top of the range, half and one ulp of max, then subnormals and min normal
  localparam fp32_t EDGE_VALS [N_EDGE] = '{32'h7f7f_ffff, 32'hff7f_ffff, 32'h7f7f_fffe,
                                            32'h7300_0000, 32'h7380_0000, 32'h0000_0001,
                                            32'h0000_0003, 32'h007f_ffff, 32'h8040_0000,
                                            32'h0080_0001};

  logic    clk_i;
  logic    reset_i;
  logic    valid_i;
  logic    sub_i;
  fp32_t   rs1_i;
  fp32_t   rs2_i;
  frm_t    frm_i;
  logic    valid_o;
  fp32_t   result_o;
  fflags_t fflags_o;

  fp32_t       exp_res_q[$];  // Expected values in send order
  fflags_t     exp_flg_q[$];
  time         sent_q[$];
  string       desc_q[$];
  fp32_t       rand_a [N_RAND];
  fp32_t       rand_b [N_RAND];
  logic [31:0] rng_state;
  int          res_errs;
  int          flg_errs;
  int          lat_errs;
  int          proto_errs;
  fp32_t       chk_res;
  fflags_t     chk_flg;
  time         chk_sent;
  string       chk_desc;

  fp_addsub_unit uut (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .valid_i  (valid_i),
    .sub_i    (sub_i),
    .rs1_i    (rs1_i),
    .rs2_i    (rs2_i),
    .frm_i    (frm_i),
    .valid_o  (valid_o),
    .result_o (result_o),
    .fflags_o (fflags_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Normal operands, exponents 64..191, every fourth pair shares the exponent
  task automatic fill_random();
    logic [31:0] w;
    fp_exp_t     ea;
    fp_exp_t     eb;
    for (int i = 0; i < N_RAND; i++) begin
      w  = next_rand();
      ea = 8'd64 + {1'b0, w[29:23]};
      rand_a[i] = {w[31], ea, w[22:0]};
      w  = next_rand();
      eb = (i % 4 == 0) ? ea : ea - 8'd16 + {3'b000, w[27:23]};
      rand_b[i] = {w[31], eb, w[22:0]};
    end
  endtask

  // One strobe per call, expected value queued with its send time
  task automatic send_op(input fp32_t a, input fp32_t b, input logic sub, input frm_t frm);
    fp32_t   er;
    fflags_t ef;
    @(posedge clk_i);
    valid_i <= 1'b1;
    rs1_i   <= a;
    rs2_i   <= b;
    sub_i   <= sub;
    frm_i   <= frm;
    ref_fadd(a, b, sub, frm, er, ef);
    exp_res_q.push_back(er);
    exp_flg_q.push_back(ef);
    sent_q.push_back($time);
    desc_q.push_back($sformatf("%h %s %h frm %0d", a, sub ? "-" : "+", b, frm));
  endtask

  task automatic go_idle();
    @(posedge clk_i);
    valid_i <= 1'b0;
  endtask

  task automatic check_result(input fp32_t got, input fp32_t exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: result %h, expected %h for %s", $time, got, exp, what);
      res_errs++;
    end
  endtask

  task automatic check_flags(input fflags_t got, input fflags_t exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: fflags %b, expected %b for %s", $time, got, exp, what);
      flg_errs++;
    end
  endtask

  // Compare on the falling edge, away from the register update
  always @(negedge clk_i) begin
    if (!reset_i && valid_o === 1'b1) begin
      if (exp_res_q.size() == 0) begin
        $display("valid_o went high at %0t although no result was outstanding", $time);
        proto_errs++;
      end else begin
        chk_res  = exp_res_q.pop_front();
        chk_flg  = exp_flg_q.pop_front();
        chk_sent = sent_q.pop_front();
        chk_desc = desc_q.pop_front();
        check_result(result_o, chk_res, chk_desc);
        check_flags(fflags_o, chk_flg, chk_desc);
        if ($time - chk_sent != 64'(CLK_PERIOD + CLK_PERIOD / 2)) begin // One cycle late
          $display("ERR %0t: answer to %s arrived %0t after send", $time, chk_desc,
                   $time - chk_sent);
          lat_errs++;
        end
      end
    end
  end

  initial begin
    #((N_VEC * 2 + 100) * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not finish", N_VEC * 2 + 100);
    $display("tests failed");
    $finish;
  end

  initial begin
    int          drain;
    logic [31:0] x;
    logic [31:0] y;
    reset_i    <= 1'b1;
    valid_i    <= 1'b0;
    sub_i      <= 1'b0;
    rs1_i      <= '0;
    rs2_i      <= '0;
    frm_i      <= '0;
    rng_state  = 32'hd009_f183;
    res_errs   = 0;
    flg_errs   = 0;
    lat_errs   = 0;
    proto_errs = 0;
    fill_random();
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;

    // Random pairs back to back, RNE first and then the other modes
    for (int m = 0; m < 5; m++) begin
      for (int i = 0; i < N_RAND; i++) begin
        send_op(rand_a[i], rand_b[i], 1'b0, frm_t'(m));
        send_op(rand_a[i], rand_b[i], 1'b1, frm_t'(m));
      end
      go_idle();
    end

    for (int m = 0; m < 5; m++) begin
      for (int i = 0; i < N_CANCEL; i++) begin
        send_op(rand_a[i], rand_a[i], 1'b1, frm_t'(m));                // x - x
        send_op(rand_a[i], rand_a[i] ^ 32'h8000_0000, 1'b0, frm_t'(m)); // x + (-x)
      end
      for (int z = 0; z < 4; z++) begin
        send_op({z[1], 31'd0}, {z[0], 31'd0}, 1'b0, frm_t'(m)); // Signed zero pairs
        send_op({z[1], 31'd0}, {z[0], 31'd0}, 1'b1, frm_t'(m));
      end
      go_idle();
    end

    // NaN and inf crossed with each other, mode rotated
    for (int i = 0; i < N_SPEC; i++) begin
      for (int j = 0; j < N_SPEC; j++) begin
        send_op(SPEC_VALS[i], SPEC_VALS[j], 1'b0, frm_t'((i + j) % 5));
        send_op(SPEC_VALS[i], SPEC_VALS[j], 1'b1, frm_t'((i + j) % 5));
      end
    end
    go_idle();

    for (int m = 0; m < 5; m++) begin
      for (int i = 0; i < N_EDGE; i++) begin
        for (int j = 0; j < N_EDGE; j++) begin
          send_op(EDGE_VALS[i], EDGE_VALS[j], 1'b0, frm_t'(m));
          send_op(EDGE_VALS[i], EDGE_VALS[j], 1'b1, frm_t'(m));
        end
      end
    end
    go_idle();

    for (int m = 5; m < 8; m++) begin
      for (int k = 0; k < N_RSV; k++) begin
        x = next_rand();
        y = next_rand();
        send_op(x, y, k[0], frm_t'(m));
      end
    end
    go_idle();

    drain = 0;
    while (exp_res_q.size() != 0 && drain < 10) begin
      @(negedge clk_i);
      drain++;
    end
    repeat (2) @(negedge clk_i); // Room for a stray strobe to show up
    if (exp_res_q.size() != 0) begin
      $display("%0d expected results were never answered by the DUT", exp_res_q.size());
      proto_errs += exp_res_q.size();
    end
    $display("errors: result %0d, flags %0d, latency %0d, protocol %0d",
             res_errs, flg_errs, lat_errs, proto_errs);
    if (res_errs + flg_errs + lat_errs + proto_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+.
fp_pkg.sv
fp_exp_align.sv
fp_lead_one.sv
fp_addsub_core.sv
fp_special_case.sv
fp_addsub_unit.sv
tb_fp_addsub.sv
